//--- hw/jtag_pkg.sv
package jtag_pkg;

    // tap states, test-logic-reset must stay at zero
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    typedef logic [31:0] ir_word_t;
    typedef logic [31:0] dr_word_t;

    // instruction codes
    localparam ir_word_t IDCODE_INSTR = 32'h0000_0001;
    localparam ir_word_t BYPASS_INSTR = 32'hFFFF_FFFF;
    localparam ir_word_t USER_INSTR   = 32'h0A0B_0C0D;

    // synchronized pin view, one clk cycle per strobe
    typedef struct packed {
        logic tck_rise;
        logic tck_fall;
        logic tms;
        logic tdi;
    } jtag_pins_t;

    // action strobes are already qualified by tck_rise
    typedef struct packed {
        logic test_logic_reset;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic shifting_ir;
        logic shifting_dr;
    } tap_ctrl_t;

    // one-hot data register select
    typedef struct packed {
        logic sel_idcode;
        logic sel_bypass;
        logic sel_user;
    } dr_select_t;

endpackage

//--- hw/tck_edge_detect.sv
`timescale 1ns/1ps

module tck_edge_detect
    import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       jtag_clk,
    input  logic       jtag_tms,
    input  logic       jtag_tdi,
    output jtag_pins_t pins
);

    // two-flop synchronizers, index 1 is the stable stage
    logic [1:0] tck_sync;
    logic [1:0] tms_sync;
    logic [1:0] tdi_sync;
    logic       tck_hist;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_sync <= '0;
            tms_sync <= '0;
            tdi_sync <= '0;
            tck_hist <= 1'b0;
            pins     <= '0;
        end
        else
        begin
            tck_sync <= {tck_sync[0], jtag_clk};
            tms_sync <= {tms_sync[0], jtag_tms};
            tdi_sync <= {tdi_sync[0], jtag_tdi};
            tck_hist <= tck_sync[1];

            // strobes and pin samples leave at the same depth
            pins.tck_rise <= tck_sync[1] & ~tck_hist;
            pins.tck_fall <= ~tck_sync[1] & tck_hist;
            pins.tms      <= tms_sync[1];
            pins.tdi      <= tdi_sync[1];
        end
    end

endmodule

//--- hw/tap_controller.sv
`timescale 1ns/1ps

module tap_controller
    import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  jtag_pins_t pins,
    output tap_ctrl_t  ctrl
);

    tap_state_e state;
    tap_state_e next_state;

    // standard 1149.1 transitions
    always_comb
    begin
        next_state = state;
        case (state)
            TEST_LOGIC_RESET:
                next_state = pins.tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:
                next_state = pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:
                next_state = pins.tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:
                next_state = pins.tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:
                next_state = pins.tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:
                next_state = pins.tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:
                next_state = pins.tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:
                next_state = pins.tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:
                next_state = pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:
                next_state = pins.tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:
                next_state = pins.tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:
                next_state = pins.tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:
                next_state = pins.tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:
                next_state = pins.tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:
                next_state = pins.tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:
                next_state = pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:
                next_state = TEST_LOGIC_RESET;
        endcase
    end

    // advance only on a tck rise
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= TEST_LOGIC_RESET;
        end
        else if (pins.tck_rise)
        begin
            state <= next_state;
        end
    end

    // actions fire with the transition out of the state
    always_comb
    begin
        ctrl.test_logic_reset = pins.tck_rise && (state == TEST_LOGIC_RESET);
        ctrl.capture_ir       = pins.tck_rise && (state == CAPTURE_IR);
        ctrl.shift_ir         = pins.tck_rise && (state == SHIFT_IR);
        ctrl.update_ir        = pins.tck_rise && (state == UPDATE_IR);
        ctrl.capture_dr       = pins.tck_rise && (state == CAPTURE_DR);
        ctrl.shift_dr         = pins.tck_rise && (state == SHIFT_DR);
        ctrl.update_dr        = pins.tck_rise && (state == UPDATE_DR);

        // levels for the falling-edge tdo mux
        ctrl.shifting_ir      = (state == SHIFT_IR);
        ctrl.shifting_dr      = (state == SHIFT_DR);
    end

endmodule

//--- hw/instruction_register.sv
`timescale 1ns/1ps

module instruction_register
    import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  jtag_pins_t pins,
    input  tap_ctrl_t  ctrl,
    output dr_select_t dr_sel,
    output logic       ir_tdo
);

    ir_word_t ir_shift;
    ir_word_t ir_update;

    // shift stage with tdi entering at the msb
    always_ff @(posedge clk)
    begin
        if (ctrl.capture_ir)
        begin
            // current instruction goes out as the captured value
            ir_shift <= ir_update;
        end
        else if (ctrl.shift_ir)
        begin
            ir_shift <= {pins.tdi, ir_shift[31:1]};
        end
    end

    // update stage holds the active instruction
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir_update <= IDCODE_INSTR;
        end
        else if (ctrl.test_logic_reset)
        begin
            ir_update <= IDCODE_INSTR;
        end
        else if (ctrl.update_ir)
        begin
            ir_update <= ir_shift;
        end
    end

    assign ir_tdo = ir_shift[0];

    // anything not recognized falls back to bypass
    always_comb
    begin
        dr_sel = '0;
        case (ir_update)
            IDCODE_INSTR:
                dr_sel.sel_idcode = 1'b1;
            USER_INSTR:
                dr_sel.sel_user = 1'b1;
            default:
                dr_sel.sel_bypass = 1'b1;
        endcase
    end

endmodule

//--- hw/data_registers.sv
`timescale 1ns/1ps

module data_registers
    import jtag_pkg::*;
#(
    parameter dr_word_t IDCODE_VALUE     = 32'h1234_5678,
    parameter dr_word_t USER_RESET_VALUE = 32'h0A0B_0C0D
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  jtag_pins_t pins,
    input  tap_ctrl_t  ctrl,
    input  dr_select_t dr_sel,
    input  logic       ir_tdo,
    output logic       jtag_tdo
);

    // shared 32-bit shift path for idcode and user
    dr_word_t dr_shift;
    logic     bypass_bit;
    dr_word_t user_reg;
    logic     dr_lsb;
    logic     tdo_next;

    always_ff @(posedge clk)
    begin
        if (ctrl.capture_dr)
        begin
            if (dr_sel.sel_idcode)
            begin
                dr_shift <= IDCODE_VALUE;
            end
            else if (dr_sel.sel_user)
            begin
                dr_shift <= user_reg;
            end
        end
        else if (ctrl.shift_dr && !dr_sel.sel_bypass)
        begin
            dr_shift <= {pins.tdi, dr_shift[31:1]};
        end
    end

    // single bypass stage that captures zero
    always_ff @(posedge clk)
    begin
        if (ctrl.capture_dr)
        begin
            bypass_bit <= 1'b0;
        end
        else if (ctrl.shift_dr && dr_sel.sel_bypass)
        begin
            bypass_bit <= pins.tdi;
        end
    end

    // user register only changes on update with user selected
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            user_reg <= USER_RESET_VALUE;
        end
        else if (ctrl.update_dr && dr_sel.sel_user)
        begin
            user_reg <= dr_shift;
        end
    end

    // lsb of the selected path
    always_comb
    begin
        if (dr_sel.sel_bypass)
        begin
            dr_lsb = bypass_bit;
        end
        else
        begin
            dr_lsb = dr_shift[0];
        end
    end

    always_comb
    begin
        if (ctrl.shifting_ir)
        begin
            tdo_next = ir_tdo;
        end
        else if (ctrl.shifting_dr)
        begin
            tdo_next = dr_lsb;
        end
        else
        begin
            tdo_next = 1'b0;
        end
    end

    // tdo changes on the falling tck edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            jtag_tdo <= 1'b0;
        end
        else if (pins.tck_fall)
        begin
            jtag_tdo <= tdo_next;
        end
    end

endmodule

//--- hw/jtag_tap_top.sv
`timescale 1ns/1ps

module jtag_tap_top
    import jtag_pkg::*;
#(
    parameter dr_word_t IDCODE_VALUE     = 32'h1234_5678,
    parameter dr_word_t USER_RESET_VALUE = 32'h0A0B_0C0D
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic jtag_clk,
    input  logic jtag_tms,
    input  logic jtag_tdi,
    output logic jtag_tdo
);

    jtag_pins_t pins;
    tap_ctrl_t  ctrl;
    dr_select_t dr_sel;
    logic       ir_tdo;

    // pin synchronizer and tck strobes
    tck_edge_detect edge_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .jtag_clk (jtag_clk),
        .jtag_tms (jtag_tms),
        .jtag_tdi (jtag_tdi),
        .pins     (pins)
    );

    tap_controller tap_i (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (pins),
        .ctrl  (ctrl)
    );

    instruction_register ir_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .pins   (pins),
        .ctrl   (ctrl),
        .dr_sel (dr_sel),
        .ir_tdo (ir_tdo)
    );

    data_registers #(
        .IDCODE_VALUE     (IDCODE_VALUE),
        .USER_RESET_VALUE (USER_RESET_VALUE)
    ) dr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pins     (pins),
        .ctrl     (ctrl),
        .dr_sel   (dr_sel),
        .ir_tdo   (ir_tdo),
        .jtag_tdo (jtag_tdo)
    );

endmodule

//--- tests/tb_jtag_tap.sv
`timescale 1ns/1ps

module tb_jtag_tap
    import jtag_pkg::*;
();

    localparam dr_word_t IDCODE_VALUE     = 32'h1234_5678;
    localparam dr_word_t USER_RESET_VALUE = 32'h0A0B_0C0D;
    localparam logic [31:0] SEED          = 32'hbdef_60c1;

    logic clk;
    logic rst_n;
    logic jtag_clk;
    logic jtag_tms;
    logic jtag_tdi;
    logic jtag_tdo;

    int err_count;
    int test_count;
    int failed_tests;
    int errs_at_start;

    jtag_tap_top #(
        .IDCODE_VALUE     (IDCODE_VALUE),
        .USER_RESET_VALUE (USER_RESET_VALUE)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .jtag_clk (jtag_clk),
        .jtag_tms (jtag_tms),
        .jtag_tdi (jtag_tdi),
        .jtag_tdo (jtag_tdo)
    );

    always #50 clk = ~clk;

    // each step lands just after a rising clk edge
    task automatic cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // one tck period, 8 clk low and 8 clk high, tdo read before the rise
    task automatic jtag_bit(input logic tms, input logic tdi, output logic tdo);
        jtag_tms = tms;
        jtag_tdi = tdi;
        cycles(4);
        tdo = jtag_tdo;
        jtag_clk = 1'b1;
        cycles(8);
        jtag_clk = 1'b0;
        cycles(4);
    endtask

    task automatic wait_tdo_low(input int limit, output logic ok);
        int n;
        n = 0;
        while (jtag_tdo !== 1'b0 && n < limit)
        begin
            cycles(1);
            n++;
        end
        ok = (jtag_tdo === 1'b0);
    endtask

    // five rises with tms high reach test-logic-reset, then idle
    task automatic reset_to_idle();
        logic unused;
        repeat (5)
        begin
            jtag_bit(1'b1, 1'b0, unused);
        end
        jtag_bit(1'b0, 1'b0, unused);
    endtask

    task automatic enter_shift_dr();
        logic unused;
        jtag_bit(1'b1, 1'b0, unused);
        jtag_bit(1'b0, 1'b0, unused);
        jtag_bit(1'b0, 1'b0, unused);
    endtask

    task automatic enter_shift_ir();
        logic unused;
        jtag_bit(1'b1, 1'b0, unused);
        jtag_bit(1'b1, 1'b0, unused);
        jtag_bit(1'b0, 1'b0, unused);
        jtag_bit(1'b0, 1'b0, unused);
    endtask

    // lsb first, optional detour through pause before bit pause_at
    task automatic shift_bits(input logic [31:0] wr, input int n, input int pause_at,
                              output logic [31:0] rd);
        logic [31:0] data;
        logic        bit_out;
        logic        unused;
        int          i;
        data = wr;
        rd   = '0;
        for (i = 0; i < n; i++)
        begin
            jtag_bit((i == n - 1) || (i == pause_at - 1), data[0], bit_out);
            rd   = {bit_out, rd[31:1]};
            data = data >> 1;
            if (i == pause_at - 1 && i != n - 1)
            begin
                // exit1 -> pause -> pause -> exit2 -> shift
                jtag_bit(1'b0, 1'b0, unused);
                jtag_bit(1'b0, 1'b0, unused);
                jtag_bit(1'b1, 1'b0, unused);
                jtag_bit(1'b0, 1'b0, unused);
            end
        end
        rd = rd >> (32 - n);
        // exit1 -> update -> idle
        jtag_bit(1'b1, 1'b0, unused);
        jtag_bit(1'b0, 1'b0, unused);
    endtask

    task automatic scan_ir(input ir_word_t wr, output ir_word_t rd);
        enter_shift_ir();
        shift_bits(wr, 32, 0, rd);
    endtask

    task automatic scan_dr(input dr_word_t wr, input int n, input int pause_at,
                           output dr_word_t rd);
        enter_shift_dr();
        shift_bits(wr, n, pause_at, rd);
    endtask

    task automatic check_ir(input string name, input ir_word_t got, input ir_word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_dr(input string name, input dr_word_t got, input dr_word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic begin_test();
        errs_at_start = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == errs_at_start)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            failed_tests++;
            $display("test %s: %0d errors", name, err_count - errs_at_start);
        end
    endtask

    task automatic test_idcode_after_reset();
        dr_word_t rd;
        begin_test();
        reset_to_idle();
        scan_dr('0, 32, 0, rd);
        check_dr("idcode dr", rd, IDCODE_VALUE);
        end_test("idcode after reset");
    endtask

    task automatic test_ir_capture();
        ir_word_t rd;
        begin_test();
        scan_ir(USER_INSTR, rd);
        check_ir("ir capture first", rd, IDCODE_INSTR);
        scan_ir(BYPASS_INSTR, rd);
        check_ir("ir capture second", rd, USER_INSTR);
        end_test("ir capture");
    endtask

    task automatic test_user_pause();
        ir_word_t rd_ir;
        dr_word_t wr;
        dr_word_t rd;
        begin_test();
        scan_ir(USER_INSTR, rd_ir);
        check_ir("ir capture", rd_ir, BYPASS_INSTR);
        wr = $urandom();
        scan_dr(wr, 32, 13, rd);
        check_dr("user reset value", rd, USER_RESET_VALUE);
        scan_dr(wr, 32, 0, rd);
        check_dr("user readback", rd, wr);
        end_test("user register with pause");
    endtask

    task automatic test_bypass();
        ir_word_t rd_ir;
        dr_word_t pattern;
        dr_word_t rd;
        begin_test();
        scan_ir(BYPASS_INSTR, rd_ir);
        check_ir("ir capture", rd_ir, USER_INSTR);
        pattern = $urandom() & 32'h0000_ffff;
        scan_dr(pattern, 16, 0, rd);
        check_dr("bypass tdo", rd, (pattern << 1) & 32'h0000_ffff);
        // unknown code must act as bypass
        scan_ir(32'h0000_0055, rd_ir);
        check_ir("ir capture bypass", rd_ir, BYPASS_INSTR);
        pattern = $urandom() & 32'h0000_ffff;
        scan_dr(pattern, 16, 0, rd);
        check_dr("unknown instr tdo", rd, (pattern << 1) & 32'h0000_ffff);
        end_test("bypass and unknown instruction");
    endtask

    task automatic test_tms_reset();
        ir_word_t rd_ir;
        dr_word_t rd;
        begin_test();
        scan_ir(USER_INSTR, rd_ir);
        check_ir("ir capture", rd_ir, 32'h0000_0055);
        reset_to_idle();
        scan_dr('0, 32, 0, rd);
        check_dr("idcode after tms reset", rd, IDCODE_VALUE);
        scan_ir(IDCODE_INSTR, rd_ir);
        check_ir("ir after tms reset", rd_ir, IDCODE_INSTR);
        end_test("tms reset");
    endtask

    initial
    begin
        logic tdo_ok;
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        jtag_clk     = 1'b0;
        jtag_tms     = 1'b0;
        jtag_tdi     = 1'b0;
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        cycles(8);
        rst_n = 1'b1;
        wait_tdo_low(32, tdo_ok);
        if (!tdo_ok)
        begin
            $display("timeout: jtag_tdo did not go low after reset");
            err_count++;
        end
        else
        begin
            test_idcode_after_reset();
            test_ir_capture();
            test_user_pause();
            test_bypass();
            test_tms_reset();
        end
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
        if (err_count == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/jtag_pkg.sv
hw/tck_edge_detect.sv
hw/tap_controller.sv
hw/instruction_register.sv
hw/data_registers.sv
hw/jtag_tap_top.sv
tests/tb_jtag_tap.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 --timescale 1ns/1ps
TOP       := tb_jtag_tap
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
